/* dv/fds_checker.sv */
`timescale 1ns/1ps
`include "fds_cfg.svh"

module fds_checker
	import fds_pkg::*;
(
	input logic        m2,
	input logic        rst,
	input cpu_bus_t    bus,
	input logic [7:0]  dout,
	input logic        bus_oe,
	input logic [11:0] vol
);

	int          errors;
	int          checks;
	logic [5:0]  shadow [64]; // Expected wave RAM contents
	logic        shadow_we;
	logic        counting;
	logic        order_on;
	int          step_cnt;
	logic [11:0] last_vol;
	logic [11:0] next_vol;

	initial
	begin
		errors = 0;
		checks = 0;
		counting = 0;
		order_on = 0;
		step_cnt = 0;
		shadow_we = 0;
	end

	// **************************************************
	// Reference functions
	// **************************************************
	function automatic logic [7:0] read_byte(input logic [5:0] val);
		return {`FDS_READ_TAG, val};
	endfunction

	// Base is 3/4 of clip * sample, then 2/2, 2/3, 2/4, 2/5 of that as shift sums
	function automatic logic [11:0] vol_ref(input int gain, input int wv, input int mv);
		int clip;
		int p;
		clip = (gain > `FDS_GAIN_CLIP) ? `FDS_GAIN_CLIP : gain;
		p = clip * wv;
		case (mv)
			0: return (p >> 1) + (p >> 2);
			1: return p >> 1;
			2: return (p >> 2) + (p >> 3);
			default: return (p >> 2) + (p >> 4);
		endcase
	endfunction

	function automatic int steps_ref(input int n, input int f);
		return (n * f) / 65536;
	endfunction

	function automatic int ramp_index(input logic [11:0] v);
		for (int k = 0; k < 64; k++)
			if (vol_ref(32, k, 0) == v)
				return k;
		return 0;
	endfunction

	// **************************************************
	// Compare tasks
	// **************************************************
	task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("error %s expected %0h actual %0h", name, exp, act);
		end
	endtask

	task automatic check_near(input string name, input int exp, input int act);
		checks++;
		if (act < exp - 1 || act > exp + 1)
		begin
			errors++;
			$display("error %s expected %0d (+-1) actual %0d", name, exp, act);
		end
	endtask

	task automatic check_gt(input string name, input int floor_val, input int act);
		checks++;
		if (act <= floor_val)
		begin
			errors++;
			$display("error %s expected more than %0d actual %0d", name, floor_val, act);
		end
	endtask

	task automatic check_order(input string name, input bit up, input int prev, input int cur);
		checks++;
		if (up ? (cur < prev) : (cur > prev))
		begin
			errors++;
			$display("%s: gain moved the wrong way from %0d to %0d", name, prev, cur);
		end
	endtask

	task automatic check_vol(input int gain, input int wv, input int mv);
		logic [11:0] exp;
		int n;
		exp = vol_ref(gain, wv, mv);
		n = 0;
		while (vol !== exp && n < 4)
		begin
			@(negedge m2);
			n++;
		end
		check_eq("scaling", exp, vol);
	endtask

	task automatic start_window(input bit ordered);
		last_vol = vol;
		step_cnt = 0;
		order_on = ordered;
		counting = 1;
	endtask

	task automatic end_window(output int cnt);
		counting = 0;
		cnt = step_cnt;
	endtask

	// Shadow RAM follows the write enable in $4089
	always @(posedge m2)
	begin
		if (rst)
			shadow_we = 0;
		else if (bus.wr_stb && !bus.rw)
		begin
			if (bus.addr == `FDS_ADDR_MASTER)
				shadow_we = bus.dat[7];
			else if (shadow_we && bus.addr[15:6] == `FDS_WAV_BASE >> 6)
				shadow[bus.addr[5:0]] = bus.dat[5:0];
		end
		if (counting && vol !== last_vol)
		begin
			step_cnt++;
			if (order_on)
			begin
				next_vol = vol_ref(32, (ramp_index(last_vol) + 1) % 64, 0);
				check_eq("wave order", next_vol, vol);
			end
			last_vol = vol;
		end
	end

	always @(negedge m2)
	begin
		if (!rst && bus.rw)
		begin
			if (bus.addr[15:6] == `FDS_WAV_BASE >> 6)
			begin
				check_eq("ram read oe", 1, bus_oe);
				check_eq("ram read", read_byte(shadow[bus.addr[5:0]]), dout);
			end
			else if (bus.addr == `FDS_ADDR_VOL_RD || bus.addr == `FDS_ADDR_MOD_RD)
				check_eq("gain read oe", 1, bus_oe);
			else
				check_eq("unmapped oe", 0, bus_oe);
		end
		else if (!rst)
			check_eq("idle oe", 0, bus_oe); // No read on the bus
	end

endmodule

/* dv/fds_tb.sv */
`timescale 1ns/1ps
`include "fds_cfg.svh"

module fds_tb
	import fds_pkg::*;
;

	localparam int WIN = 2000;      // Step counting window in cycles
	localparam int RAMP_MAX = 2500; // Poll budget for one envelope ramp
	localparam int WAVE_F = 1000;
	localparam int MOD_F = 400;
	localparam int TEST_CYCLES = 16 + 320 + 40 + 400 + 2 * RAMP_MAX + 500 + 3 * WIN + 700;
	localparam int LIMIT = TEST_CYCLES * 5 / 4;

	logic        m2;
	logic        rst;
	cpu_bus_t    bus;
	logic [7:0]  dout;
	logic        bus_oe;
	logic [11:0] vol;
	integer      seed;
	int          cycles;
	logic [7:0]  rd;
	int          g1;
	int          g2;
	int          wv;
	int          prev;
	int          n;
	int          cnt_plain;
	int          cnt_mod;
	int          cnt_zero;

	fds_audio uut (.m2(m2), .rst(rst), .bus(bus), .dout(dout), .bus_oe(bus_oe), .vol(vol));

	fds_checker chk (.m2(m2), .rst(rst), .bus(bus), .dout(dout), .bus_oe(bus_oe), .vol(vol));

	initial
	begin
		m2 = 0;
		forever #10 m2 = ~m2;
	end

	always @(posedge m2)
	begin
		cycles++;
		if (cycles >= LIMIT)
		begin
			$display("timeout: run passed the %0d cycle limit", LIMIT);
			$display("errors: %0d of %0d checks", chk.errors, chk.checks);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic bus_write(input logic [15:0] addr, input logic [7:0] dat);
		@(posedge m2);
		#2;
		bus.addr = addr;
		bus.dat = dat;
		bus.rw = 0;
		bus.wr_stb = 1;
		@(posedge m2);
		#2;
		bus.wr_stb = 0;
	endtask

	task automatic bus_read(input logic [15:0] addr, output logic [7:0] dat);
		@(posedge m2);
		#2;
		bus.addr = addr;
		bus.rw = 1;
		@(negedge m2);
		dat = dout;
	endtask

	task automatic count_steps(input bit ordered, output int cnt);
		chk.start_window(ordered);
		repeat (WIN) @(posedge m2);
		#2; // Close the window clear of the edge
		chk.end_window(cnt);
	endtask

	initial
	begin
		seed = 32'h99c39d4b;
		cycles = 0;
		rst = 1;
		bus = '{addr: '0, dat: '0, rw: 1'b0, wr_stb: 1'b0};
		repeat (16) @(posedge m2);
		#2;
		rst = 0;

		// Wave RAM fill and readback
		bus_write(`FDS_ADDR_MASTER, 8'h80);
		for (int i = 0; i < 64; i++)
			bus_write(`FDS_WAV_BASE + i, $random(seed) & 8'h3f);
		for (int i = 0; i < 64; i++)
			bus_read(`FDS_WAV_BASE + i, rd);
		bus_read(16'h4000, rd);
		bus_read(16'h4081, rd);
		bus_read(16'h5040, rd);

		// Direct gains
		g1 = $random(seed) & 63;
		g2 = $random(seed) & 63;
		bus_write(`FDS_ADDR_VOL_ENV, 8'h80 | g1);
		bus_write(`FDS_ADDR_MOD_ENV, 8'h80 | g2);
		bus_read(`FDS_ADDR_VOL_RD, rd);
		chk.check_eq("vol gain read", chk.read_byte(g1), rd);
		bus_read(`FDS_ADDR_MOD_RD, rd);
		chk.check_eq("mod gain read", chk.read_byte(g2), rd);

		// Output scaling from RAM entry 0
		wv = $random(seed) & 63;
		bus_write(`FDS_ADDR_WAV_FHI, 8'h80);
		bus_write(`FDS_ADDR_MASTER, 8'h80);
		bus_write(`FDS_WAV_BASE, wv);
		for (int mv = 0; mv < 4; mv++)
			for (int i = 0; i < 8; i++)
			begin
				g1 = (i == 0) ? 63 : ($random(seed) & 63);
				bus_write(`FDS_ADDR_VOL_ENV, 8'h80 | g1);
				bus_write(`FDS_ADDR_MASTER, mv);
				chk.check_vol(g1, wv, mv);
			end

		// Envelope ramps up, down, and halted
		bus_write(`FDS_ADDR_ENV_SPD, 8'd1);
		bus_write(`FDS_ADDR_VOL_ENV, 8'h80);
		bus_write(`FDS_ADDR_VOL_ENV, 8'h42);
		prev = 0;
		n = 0;
		do
		begin
			bus_read(`FDS_ADDR_VOL_RD, rd);
			chk.check_order("env up", 1, prev, rd[5:0]);
			prev = rd[5:0];
			n++;
		end
		while (prev != 32 && n < RAMP_MAX);
		chk.check_eq("env up top", 32, prev);
		repeat (100)
		begin
			bus_read(`FDS_ADDR_VOL_RD, rd);
			chk.check_eq("env up hold", 32, rd[5:0]);
		end
		bus_write(`FDS_ADDR_VOL_ENV, 8'h02);
		n = 0;
		do
		begin
			bus_read(`FDS_ADDR_VOL_RD, rd);
			chk.check_order("env down", 0, prev, rd[5:0]);
			prev = rd[5:0];
			n++;
		end
		while (prev != 0 && n < RAMP_MAX);
		chk.check_eq("env down bottom", 0, prev);
		bus_write(`FDS_ADDR_VOL_ENV, 8'h8a);
		bus_write(`FDS_ADDR_VOL_ENV, 8'h41);
		bus_write(`FDS_ADDR_WAV_FHI, 8'hc0); // Halt with the wave still off
		repeat (200)
		begin
			bus_read(`FDS_ADDR_VOL_RD, rd);
			chk.check_eq("env halt", 10, rd[5:0]);
		end
		bus_write(`FDS_ADDR_WAV_FHI, 8'h80);
		bus_write(`FDS_ADDR_ENV_SPD, 8'd0);

		// Wave stepping over a rising ramp
		bus_write(`FDS_ADDR_MASTER, 8'h80);
		for (int i = 0; i < 64; i++)
			bus_write(`FDS_WAV_BASE + i, i);
		bus_write(`FDS_ADDR_MASTER, 8'h00);
		bus_write(`FDS_ADDR_VOL_ENV, 8'ha0);
		bus_write(`FDS_ADDR_MOD_ENV, 8'h80);
		bus_write(`FDS_ADDR_MOD_FHI, 8'h80);
		bus_write(`FDS_ADDR_SWEEP_CTR, 8'h00);
		bus_write(`FDS_ADDR_WAV_FLO, WAVE_F & 8'hff);
		bus_write(`FDS_ADDR_WAV_FHI, WAVE_F >> 8);
		count_steps(1, cnt_plain);
		chk.check_near("wave steps", chk.steps_ref(WIN, WAVE_F), cnt_plain);

		// Modulation with +4 codes, then with code 0
		for (int i = 0; i < 32; i++)
			bus_write(`FDS_ADDR_MOD_TBL, 8'd3);
		bus_write(`FDS_ADDR_SWEEP_CTR, 8'h00);
		bus_write(`FDS_ADDR_MOD_ENV, 8'h80 | 20);
		bus_write(`FDS_ADDR_MOD_FLO, MOD_F & 8'hff);
		bus_write(`FDS_ADDR_MOD_FHI, MOD_F >> 8);
		count_steps(1, cnt_mod);
		chk.check_gt("mod steps", cnt_plain, cnt_mod);
		bus_write(`FDS_ADDR_MOD_FHI, 8'h80);
		for (int i = 0; i < 32; i++)
			bus_write(`FDS_ADDR_MOD_TBL, 8'd0);
		bus_write(`FDS_ADDR_SWEEP_CTR, 8'h00);
		bus_write(`FDS_ADDR_MOD_FHI, MOD_F >> 8);
		count_steps(1, cnt_zero);
		chk.check_near("flat mod steps", chk.steps_ref(WIN, WAVE_F), cnt_zero);

		$display("errors: %0d of %0d checks", chk.errors, chk.checks);
		if (chk.errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+src
src/fds_pkg.sv
src/fds_wave.sv
src/fds_mod_table.sv
src/fds_pitch_calc.sv
src/fds_envelope.sv
src/fds_env_timer.sv
src/fds_audio.sv
dv/fds_checker.sv
dv/fds_tb.sv

/* src/fds_audio.sv */
`timescale 1ns/1ps
`include "fds_cfg.svh"

module fds_audio
	import fds_pkg::*;
(
	input  logic        m2,
	input  logic        rst,
	input  cpu_bus_t    bus,
	output logic [7:0]  dout,
	output logic        bus_oe,
	output logic [11:0] vol
);

	wave_regs_t        wregs;
	logic [5:0]        wav_val;
	logic [5:0]        ram_val;
	logic              ram_oe;
	logic signed [6:0] sweep_ctr;
	logic [5:0]        vol_gain;
	logic [5:0]        mod_gain;
	logic [14:0]       step;
	logic              gain_oe;
	logic [5:0]        vol_clip;
	logic [11:0]       volx;

	fds_wave u_wave (
		.m2     (m2),
		.rst    (rst),
		.bus    (bus),
		.step   (step),
		.wregs  (wregs),
		.wav_val(wav_val),
		.ram_val(ram_val),
		.ram_oe (ram_oe)
	);

	fds_mod_table u_mod (.m2(m2), .rst(rst), .bus(bus), .sweep_ctr(sweep_ctr));

	fds_pitch_calc u_pitch (
		.sweep_ctr(sweep_ctr),
		.mod_gain (mod_gain),
		.freq     (wregs.freq),
		.step     (step)
	);

	fds_env_timer u_env (
		.m2      (m2),
		.rst     (rst),
		.bus     (bus),
		.wregs   (wregs),
		.vol_gain(vol_gain),
		.mod_gain(mod_gain)
	);

	// **************************************************
	// CPU readback
	// **************************************************
	assign gain_oe = bus.rw & ((bus.addr == `FDS_ADDR_VOL_RD) | (bus.addr == `FDS_ADDR_MOD_RD));
	assign bus_oe = gain_oe | ram_oe;
	assign dout = {`FDS_READ_TAG,
		ram_oe ? ram_val : ((bus.addr == `FDS_ADDR_VOL_RD) ? vol_gain : mod_gain)};

	// Master volume scales by 2/2, 2/3, 2/4 or 2/5 as sums of shifts
	assign vol_clip = (vol_gain > 6'(`FDS_GAIN_CLIP)) ? 6'(`FDS_GAIN_CLIP) : vol_gain;
	assign volx = vol_clip * wav_val;
	assign vol = ((wregs.master_vol == 2'd3) ? {5'd0, volx[10:4]} : 12'd0)
		+ ((wregs.master_vol == 2'd2) ? {4'd0, volx[10:3]} : 12'd0)
		+ ((wregs.master_vol == 2'd1) ? 12'd0 : {3'd0, volx[10:2]})
		+ (wregs.master_vol[1] ? 12'd0 : {2'd0, volx[10:1]});

endmodule

/* src/fds_cfg.svh */
`ifndef FDS_CFG_SVH
`define FDS_CFG_SVH

// **************************************************
// Sound register map
// **************************************************
`define FDS_ADDR_VOL_ENV   16'h4080
`define FDS_ADDR_WAV_FLO   16'h4082
`define FDS_ADDR_WAV_FHI   16'h4083
`define FDS_ADDR_MOD_ENV   16'h4084
`define FDS_ADDR_SWEEP_CTR 16'h4085
`define FDS_ADDR_MOD_FLO   16'h4086
`define FDS_ADDR_MOD_FHI   16'h4087
`define FDS_ADDR_MOD_TBL   16'h4088
`define FDS_ADDR_MASTER    16'h4089
`define FDS_ADDR_ENV_SPD   16'h408A
`define FDS_ADDR_VOL_RD    16'h4090
`define FDS_ADDR_MOD_RD    16'h4092

`define FDS_WAV_BASE       16'h4040 // Start of the 64 byte wave window
`define FDS_WAV_DEPTH      64
`define FDS_MOD_DEPTH      32
`define FDS_ENV_PRESCALE   8        // m2 cycles per envelope base tick
`define FDS_GAIN_CLIP      32
`define FDS_READ_TAG       2'b01    // Open bus bits seen above every readback

`endif

/* src/fds_env_timer.sv */
`timescale 1ns/1ps
`include "fds_cfg.svh"

module fds_env_timer
	import fds_pkg::*;
(
	input  logic       m2,
	input  logic       rst,
	input  cpu_bus_t   bus,
	input  wave_regs_t wregs,
	output logic [5:0] vol_gain,
	output logic [5:0] mod_gain
);

	localparam int PRESC_W = $clog2(`FDS_ENV_PRESCALE);

	logic [PRESC_W-1:0] presc;
	logic [7:0]         env_spd;
	logic [7:0]         env_ctr;
	logic               presc_end;
	logic               env_tick;

	assign presc_end = presc == PRESC_W'(`FDS_ENV_PRESCALE - 1);
	assign env_tick = presc_end & (env_ctr == 8'd0) & (env_spd != 8'd0); // Speed 0 stops both units

	always_ff @(posedge m2)
	begin
		if (rst)
		begin
			presc <= '0;
			env_spd <= '0;
			env_ctr <= '0;
		end
		else
		begin
			if (bus_write(bus, `FDS_ADDR_ENV_SPD))
				env_spd <= bus.dat;

			if (wregs.env_halt)
			begin
				presc <= '0;
				env_ctr <= env_spd;
			end
			else
			begin
				presc <= presc_end ? '0 : presc + PRESC_W'(1);
				if (presc_end)
					env_ctr <= (env_ctr == 8'd0) ? env_spd : env_ctr - 8'd1;
			end
		end
	end

	// **************************************************
	// Volume and sweep envelopes
	// **************************************************
	fds_envelope u_vol_env (
		.m2      (m2),
		.rst     (rst),
		.bus     (bus),
		.mode_we (bus_write(bus, `FDS_ADDR_VOL_ENV)),
		.env_tick(env_tick),
		.halt    (wregs.env_halt),
		.gain    (vol_gain)
	);

	fds_envelope u_mod_env (
		.m2      (m2),
		.rst     (rst),
		.bus     (bus),
		.mode_we (bus_write(bus, `FDS_ADDR_MOD_ENV)),
		.env_tick(env_tick),
		.halt    (wregs.env_halt),
		.gain    (mod_gain)
	);

endmodule

/* src/fds_envelope.sv */
`timescale 1ns/1ps
`include "fds_cfg.svh"

module fds_envelope
	import fds_pkg::*;
(
	input  logic       m2,
	input  logic       rst,
	input  cpu_bus_t   bus,
	input  logic       mode_we,
	input  logic       env_tick,
	input  logic       halt,
	output logic [5:0] gain
);

	logic       direct; // Gain comes straight from the mode write
	logic       dir;    // High ramps up
	logic [5:0] spd;
	logic [5:0] div;
	logic       env_step;

	assign env_step = env_tick & !direct & !halt & (div == 6'd0);

	always_ff @(posedge m2)
	begin
		if (rst)
		begin
			direct <= 1'b1;
			dir <= 1'b0;
			spd <= '0;
			div <= '0;
			gain <= '0;
		end
		else
		begin
			if (mode_we)
			begin
				direct <= bus.dat[7];
				dir <= bus.dat[6];
				spd <= bus.dat[5:0];
				div <= bus.dat[5:0];
			end
			else if (halt)
				div <= spd;
			else if (env_tick & !direct)
				div <= (div == 6'd0) ? spd : div - 6'd1;

			if (mode_we & bus.dat[7])
				gain <= bus.dat[5:0];
			else if (env_step)
			begin
				if (dir & (gain < 6'(`FDS_GAIN_CLIP)))
					gain <= gain + 6'd1;
				else if (!dir & (gain != 6'd0))
					gain <= gain - 6'd1;
			end
		end
	end

endmodule

/* src/fds_mod_table.sv */
`timescale 1ns/1ps
`include "fds_cfg.svh"

module fds_mod_table
	import fds_pkg::*;
(
	input  logic               m2,
	input  logic               rst,
	input  cpu_bus_t           bus,
	output logic signed [6:0]  sweep_ctr
);

	logic [2:0]        mod_table [`FDS_MOD_DEPTH];
	logic [11:0]       mod_freq;
	logic              mod_off;
	logic [5:0]        mod_pos; // Two positions per table entry
	logic [17:0]       mod_ctr;
	logic              mod_act;
	logic              mod_tick;
	logic              tbl_we;
	logic [2:0]        mod_code;
	logic signed [6:0] sweep_next;

	assign mod_act = !mod_off & (mod_freq != 12'd0);
	assign mod_tick = (mod_ctr[17] != mod_ctr[16]) & mod_act;
	assign tbl_we = bus_write(bus, `FDS_ADDR_MOD_TBL) & mod_off; // Table loads only when halted
	assign mod_code = mod_table[mod_pos[5:1]];

	always_comb
	begin
		case (mod_code)
			3'd0: sweep_next = sweep_ctr;
			3'd1: sweep_next = sweep_ctr + 7'sd1;
			3'd2: sweep_next = sweep_ctr + 7'sd2;
			3'd3: sweep_next = sweep_ctr + 7'sd4;
			3'd4: sweep_next = '0;
			3'd5: sweep_next = sweep_ctr - 7'sd4;
			3'd6: sweep_next = sweep_ctr - 7'sd2;
			default: sweep_next = sweep_ctr - 7'sd1;
		endcase
	end

	always_ff @(posedge m2)
	begin
		if (tbl_we)
			mod_table[mod_pos[5:1]] <= bus.dat[2:0];
	end

	always_ff @(posedge m2)
	begin
		if (rst)
		begin
			mod_freq <= '0;
			mod_off <= 1'b0;
			mod_pos <= '0;
			mod_ctr <= '0;
			sweep_ctr <= '0;
		end
		else
		begin
			if (bus_write(bus, `FDS_ADDR_MOD_FLO))
				mod_freq[7:0] <= bus.dat;
			if (bus_write(bus, `FDS_ADDR_MOD_FHI))
			begin
				mod_freq[11:8] <= bus.dat[3:0];
				mod_off <= bus.dat[7];
			end

			if (bus_write(bus, `FDS_ADDR_SWEEP_CTR))
			begin
				sweep_ctr <= bus.dat[6:0];
				mod_pos[0] <= 1'b0; // Realign to the first half of the entry
			end
			else if (tbl_we)
				mod_pos[5:1] <= mod_pos[5:1] + 5'd1;
			else if (mod_tick)
			begin
				sweep_ctr <= sweep_next;
				mod_pos <= mod_pos + 6'd1;
			end

			if (mod_off)
				mod_ctr[16:0] <= '0;
			else if (mod_act)
				mod_ctr[16:0] <= mod_ctr[16:0] + {5'd0, mod_freq};
			mod_ctr[17] <= mod_ctr[16];
		end
	end

endmodule

/* src/fds_pitch_calc.sv */
`timescale 1ns/1ps

module fds_pitch_calc
(
	input  logic [6:0]  sweep_ctr,
	input  logic [5:0]  mod_gain,
	input  logic [11:0] freq,
	output logic [14:0] step
);

	logic        neg_in;
	logic [6:0]  mag;
	logic [11:0] prod;
	logic [7:0]  coarse;
	logic [7:0]  rounded;
	logic        wrap_pos;
	logic        wrap_neg;
	logic        neg_out;
	logic [7:0]  wrapped;
	logic [7:0]  bend_mag;
	logic [19:0] scaled;
	logic [13:0] bend;

	assign neg_in = sweep_ctr[6];
	assign mag = neg_in ? (~sweep_ctr + 7'd1) : sweep_ctr;
	assign prod = mag * mod_gain; // At most 64 * 63, fits 12 bits

	// Any fraction rounds away from zero, by two for positive counts
	assign coarse = prod[11:4];
	assign rounded = (prod[3:0] != 4'd0) ? (neg_in ? coarse + 8'd1 : coarse + 8'd2) : coarse;

	// Out of range results fold back with the sign flipped
	assign wrap_pos = !neg_in & (rounded >= 8'd192);
	assign wrap_neg = neg_in & (rounded >= 8'd64);
	assign neg_out = (wrap_pos | wrap_neg) ? !neg_in : neg_in;
	assign wrapped = (wrap_pos | wrap_neg) ? (~rounded + 8'd1) : rounded;
	assign bend_mag = wrap_pos ? wrapped + 8'd2 : wrapped;

	assign scaled = bend_mag * freq;
	assign bend = (scaled[5:0] >= 6'd32) ? scaled[19:6] + 14'd1 : scaled[19:6];

	assign step = neg_out ? {3'b000, freq} - {1'b0, bend} : {3'b000, freq} + {1'b0, bend};

endmodule

/* src/fds_pkg.sv */
package fds_pkg;

	// CPU side of the sound registers
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dat;
		logic        rw;     // High for a read
		logic        wr_stb; // One cycle per write
	} cpu_bus_t;

	// Wave channel registers that other blocks depend on
	typedef struct packed {
		logic [11:0] freq;
		logic        wav_off;
		logic        env_halt;
		logic [1:0]  master_vol;
	} wave_regs_t;

	// True on the cycle a register at addr is written
	function automatic logic bus_write(input cpu_bus_t b, input logic [15:0] addr);
		logic hit;
		hit = b.wr_stb & !b.rw & (b.addr == addr);
		return hit;
	endfunction

endpackage

/* src/fds_wave.sv */
`timescale 1ns/1ps
`include "fds_cfg.svh"

module fds_wave
	import fds_pkg::*;
(
	input  logic        m2,
	input  logic        rst,
	input  cpu_bus_t    bus,
	input  logic [14:0] step,
	output wave_regs_t  wregs,
	output logic [5:0]  wav_val,
	output logic [5:0]  ram_val,
	output logic        ram_oe
);

	logic [5:0]  wav_ram [`FDS_WAV_DEPTH];
	logic        ram_we_on;
	logic [5:0]  wav_addr;
	logic [17:0] wav_ctr; // Bit 17 holds last cycle's carry
	logic        ram_area;
	logic        ram_we;
	logic        wav_tick;

	assign ram_area = {bus.addr[15:6], 6'd0} == `FDS_WAV_BASE;
	assign ram_we = ram_area & bus.wr_stb & !bus.rw & ram_we_on;
	assign ram_oe = ram_area & bus.rw;
	assign ram_val = wav_ram[bus.addr[5:0]];

	// Any change of the carry bit moves to the next sample
	assign wav_tick = (wav_ctr[17] != wav_ctr[16]) & !wregs.wav_off;

	always_ff @(posedge m2)
	begin
		if (ram_we)
			wav_ram[bus.addr[5:0]] <= bus.dat[5:0];
	end

	always_ff @(posedge m2)
	begin
		if (rst)
		begin
			wregs <= '{freq: '0, wav_off: 1'b1, env_halt: 1'b0, master_vol: '0};
			ram_we_on <= 1'b0;
			wav_addr <= '0;
			wav_ctr <= '0;
			wav_val <= '0;
		end
		else
		begin
			if (bus_write(bus, `FDS_ADDR_WAV_FLO))
				wregs.freq[7:0] <= bus.dat;
			if (bus_write(bus, `FDS_ADDR_WAV_FHI))
			begin
				wregs.freq[11:8] <= bus.dat[3:0];
				wregs.wav_off <= bus.dat[7];
				wregs.env_halt <= bus.dat[6];
			end
			if (bus_write(bus, `FDS_ADDR_MASTER))
			begin
				ram_we_on <= bus.dat[7];
				wregs.master_vol <= bus.dat[1:0];
			end

			if (wregs.wav_off)
			begin
				wav_ctr[16:0] <= '0;
				wav_addr <= '0;
			end
			else
			begin
				wav_ctr[16:0] <= wav_ctr[16:0] + {2'b00, step};
				if (wav_tick)
					wav_addr <= wav_addr + 6'd1;
			end
			wav_ctr[17] <= wav_ctr[16];

			if (!ram_we_on) // Output holds while the CPU owns the RAM
				wav_val <= wav_ram[wav_addr];
		end
	end

endmodule
